//--- verilog/bus_pkg.sv
`default_nettype none

package bus_pkg;

	// widths with a meaning on the CPU and bus side
	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [7:0] byte_t;
	// holds 0..4, one more than the largest byte index
	typedef logic [2:0] byte_cnt_t;

	// load/store operations as seen from the CPU
	typedef enum logic [2:0] {
		READB,
		READBU,
		READH,
		READHU,
		READW,
		WRITEB,
		WRITEH,
		WRITEW
	} bus_op_t;

	// decoded op attributes, 5 bits
	typedef struct packed {
		byte_cnt_t cnt;
		logic sext;
		logic wr;
	} op_info_t;

	// request as held by the CPU, 67 bits
	typedef struct packed {
		bus_op_t op;
		addr_t addr;
		word_t data;
	} bus_req_t;

	// wishbone master outputs bundled for the slave, 43 bits
	typedef struct packed {
		addr_t adr;
		byte_t dat;
		logic cyc;
		logic stb;
		logic we;
	} wb_m2s_t;

	// sequencer states
	typedef enum logic [1:0] {
		IDLE,
		XFER,
		DONE
	} seq_state_t;

endpackage

`default_nettype wire

//--- verilog/bus_op_decode.sv
`timescale 1ns/1ps
`default_nettype none

module bus_op_decode
	import bus_pkg::*;
(
	input wire bus_op_t op,
	output op_info_t info
);

	always_comb begin
		// defaults cover the single byte signed read
		info.cnt = byte_cnt_t'(1);
		info.sext = 1'b1;
		info.wr = 1'b0;

		// number of byte transfers needed
		case (op)
			READW, WRITEW: begin
				info.cnt = byte_cnt_t'(4);
			end
			READH, READHU, WRITEH: begin
				info.cnt = byte_cnt_t'(2);
			end
			default: begin
				info.cnt = byte_cnt_t'(1);
			end
		endcase

		// unsigned loads are the only ones without sign extension
		case (op)
			READBU, READHU: begin
				info.sext = 1'b0;
			end
			default: begin
				info.sext = 1'b1;
			end
		endcase

		// stores drive WE on the bus
		case (op)
			WRITEB, WRITEH, WRITEW: begin
				info.wr = 1'b1;
			end
			default: begin
				info.wr = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/bus_wb8_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module bus_wb8_ctrl
	import bus_pkg::*;
(
	input wire CLK_I,
	input wire RST_I,
	input wire en,
	input wire op_info_t info,
	input wire ack,
	output logic busy,
	output logic done,
	output logic cyc,
	output logic we,
	output logic stb_en,
	output byte_cnt_t addr_cnt,
	output logic ack_take,
	output byte_cnt_t ack_cnt
);

	seq_state_t state;
	seq_state_t state_nxt;

	// ack count after taking the current ack
	byte_cnt_t ack_cnt_inc;
	// last expected ack is on the bus this cycle
	logic ack_last;
	// strobes still owed to the bus
	logic addr_pending;

	assign ack_cnt_inc = ack_cnt + byte_cnt_t'(1);
	assign addr_pending = (addr_cnt != info.cnt);

	// acks only count while a transfer is open
	assign ack_take = ack && (state == XFER);
	assign ack_last = ack_take && (ack_cnt_inc == info.cnt);

	// first strobe is launched from IDLE so it shows up in the first XFER cycle
	always_comb begin
		stb_en = 1'b0;
		if ((state == IDLE) && en) begin
			stb_en = addr_pending;
		end else if (state == XFER) begin
			stb_en = addr_pending;
		end
	end

	// next state
	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				// request is only accepted here
				if (en) begin
					state_nxt = XFER;
				end
			end
			XFER: begin
				// leave as soon as the final byte is acknowledged
				if (ack_last) begin
					state_nxt = DONE;
				end
			end
			DONE: begin
				// single cycle, requester drops en afterwards
				state_nxt = IDLE;
			end
			default: begin
				state_nxt = IDLE;
			end
		endcase
	end

	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// strobe and ack counters
	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			addr_cnt <= '0;
			ack_cnt <= '0;
		end else if (state == DONE) begin
			// ready for the next request
			addr_cnt <= '0;
			ack_cnt <= '0;
		end else begin
			if (stb_en) begin
				addr_cnt <= addr_cnt + byte_cnt_t'(1);
			end
			if (ack_take) begin
				ack_cnt <= ack_cnt_inc;
			end
		end
	end

	// status towards the CPU
	assign busy = (state == XFER);
	assign done = (state == DONE);

	// cycle spans every strobe and ack of the request
	assign cyc = (state == XFER);
	assign we = cyc && info.wr;

endmodule

`default_nettype wire

//--- verilog/bus_wb8_lane.sv
`timescale 1ns/1ps
`default_nettype none

module bus_wb8_lane
	import bus_pkg::*;
(
	input wire CLK_I,
	input wire RST_I,
	input wire bus_req_t req,
	input wire stb_en,
	input wire byte_cnt_t addr_cnt,
	output addr_t adr,
	output byte_t dat,
	output logic stb
);

	// write byte for the current strobe, little endian
	byte_t wr_byte;

	always_comb begin
		case (addr_cnt)
			byte_cnt_t'(0): wr_byte = req.data[7:0];
			byte_cnt_t'(1): wr_byte = req.data[15:8];
			byte_cnt_t'(2): wr_byte = req.data[23:16];
			default: wr_byte = req.data[31:24];
		endcase
	end

	// one strobe per issued byte
	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			stb <= 1'b0;
		end else begin
			stb <= stb_en;
		end
	end

	// address and data only move with a strobe
	always_ff @(posedge CLK_I) begin
		if (stb_en) begin
			// byte addresses just increment, no alignment
			adr <= req.addr + addr_t'(addr_cnt);
			dat <= wr_byte;
		end
	end

endmodule

`default_nettype wire

//--- verilog/bus_wb8_rdata.sv
`timescale 1ns/1ps
`default_nettype none

module bus_wb8_rdata
	import bus_pkg::*;
(
	input wire CLK_I,
	input wire RST_I,
	input wire op_info_t info,
	input wire ack_take,
	input wire byte_cnt_t ack_cnt,
	input wire byte_t dat,
	output word_t rdata
);

	// fill bit for the upper bits of short loads
	logic ext;
	// only loads update the result word
	logic take_rd;

	assign ext = dat[7] && info.sext;
	assign take_rd = ack_take && !info.wr;

	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			rdata <= '0;
		end else if (take_rd) begin
			case (ack_cnt)
				byte_cnt_t'(0): begin
					// byte 0 sets the whole word
					// the upper bytes get overwritten later for wider loads
					rdata <= {{24{ext}}, dat};
				end
				byte_cnt_t'(1): begin
					// halfword sign comes from the second byte
					rdata[31:8] <= {{16{ext}}, dat};
				end
				byte_cnt_t'(2): begin
					rdata[23:16] <= dat;
				end
				default: begin
					rdata[31:24] <= dat;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/wb8_ram.sv
`timescale 1ns/1ps
`default_nettype none

module wb8_ram
	import bus_pkg::*;
#(
	parameter int ADDR_BITS = 10,
	parameter int ACK_DELAY = 1
) (
	input wire CLK_I,
	input wire RST_I,
	input wire wb_m2s_t bus,
	output byte_t dat,
	output logic ack
);

	// ack comes out ACK_DELAY+1 cycles after its strobe
	localparam int DEPTH = ACK_DELAY + 1;
	localparam int WORDS = 2 ** ADDR_BITS;

	byte_t mem [WORDS];

	// read data and valid per pipeline stage
	byte_t pipe_dat [DEPTH];
	logic [DEPTH-1:0] pipe_vld;

	// accepted strobe this cycle
	logic stb_take;
	logic [ADDR_BITS-1:0] idx;

	assign stb_take = bus.cyc && bus.stb;

	// upper address bits are ignored so the RAM wraps
	assign idx = bus.adr[ADDR_BITS-1:0];

	// writes land at the strobe itself
	always_ff @(posedge CLK_I) begin
		if (stb_take && bus.we) begin
			mem[idx] <= bus.dat;
		end
	end

	// data side of the delay line, no reset needed
	always_ff @(posedge CLK_I) begin
		pipe_dat[0] <= mem[idx];
		for (int i = 1; i < DEPTH; i++) begin
			pipe_dat[i] <= pipe_dat[i-1];
		end
	end

	// valid side, one bit per pending ack
	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			pipe_vld <= '0;
		end else begin
			pipe_vld[0] <= stb_take;
			for (int i = 1; i < DEPTH; i++) begin
				pipe_vld[i] <= pipe_vld[i-1];
			end
		end
	end

	// last stage drives the bus
	assign ack = pipe_vld[DEPTH-1];
	assign dat = pipe_dat[DEPTH-1];

endmodule

`default_nettype wire

//--- verilog/bus_wb8_top.sv
`timescale 1ns/1ps
`default_nettype none

module bus_wb8_top
	import bus_pkg::*;
#(
	parameter int ADDR_BITS = 10,
	parameter int ACK_DELAY = 1
) (
	input wire CLK_I,
	input wire RST_I,
	input wire en,
	input wire bus_req_t req,
	output logic busy,
	output logic done,
	output word_t rdata
);

	op_info_t info;

	// controller to lane and read units
	logic stb_en;
	byte_cnt_t addr_cnt;
	logic ack_take;
	byte_cnt_t ack_cnt;

	// wishbone master side
	logic wb_cyc;
	logic wb_we;
	logic wb_stb;
	addr_t wb_adr;
	byte_t wb_dat;
	wb_m2s_t wb_bus;

	// wishbone slave side
	byte_t ram_dat;
	logic ram_ack;

	// master signals go to the RAM as one bundle
	assign wb_bus = '{adr: wb_adr, dat: wb_dat, cyc: wb_cyc, stb: wb_stb, we: wb_we};

	bus_op_decode decode_i (.op(req.op), .info(info));

	bus_wb8_ctrl ctrl_i (
		.CLK_I(CLK_I), .RST_I(RST_I), .en(en), .info(info), .ack(ram_ack),
		.busy(busy), .done(done), .cyc(wb_cyc), .we(wb_we),
		.stb_en(stb_en), .addr_cnt(addr_cnt), .ack_take(ack_take), .ack_cnt(ack_cnt)
	);

	bus_wb8_lane lane_i (
		.CLK_I(CLK_I), .RST_I(RST_I), .req(req), .stb_en(stb_en), .addr_cnt(addr_cnt),
		.adr(wb_adr), .dat(wb_dat), .stb(wb_stb)
	);

	bus_wb8_rdata rdata_i (
		.CLK_I(CLK_I), .RST_I(RST_I), .info(info), .ack_take(ack_take),
		.ack_cnt(ack_cnt), .dat(ram_dat), .rdata(rdata)
	);

	wb8_ram #(
		.ADDR_BITS(ADDR_BITS),
		.ACK_DELAY(ACK_DELAY)
	) ram_i (
		.CLK_I(CLK_I), .RST_I(RST_I), .bus(wb_bus), .dat(ram_dat), .ack(ram_ack)
	);

endmodule

`default_nettype wire

//--- dv/bus_wb8_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bus_wb8_tb
	import bus_pkg::*;
();

	localparam int ADDR_BITS = 10;
	localparam int ACK_DELAY = 1;
	localparam int MEM_BYTES = 2 ** ADDR_BITS;
	// cycles allowed per request before giving up
	localparam int TIMEOUT = 50;

	logic CLK_I;
	logic RST_I;
	logic en;
	bus_req_t req;
	logic busy;
	logic done;
	word_t rdata;

	// reference copy of the RAM contents
	byte_t model_mem [MEM_BYTES];

	// stimulus table, one entry per directed test
	bus_op_t op_q [$];
	addr_t addr_q [$];
	word_t data_q [$];
	bit chk_q [$];
	string name_q [$];

	integer seed;
	int errors;
	int checks;
	int tests;
	bit timed_out;

	bus_wb8_top #(
		.ADDR_BITS(ADDR_BITS),
		.ACK_DELAY(ACK_DELAY)
	) dut_i (
		.CLK_I(CLK_I), .RST_I(RST_I), .en(en), .req(req),
		.busy(busy), .done(done), .rdata(rdata)
	);

	initial begin
		CLK_I = 1'b0;
		forever #10 CLK_I = ~CLK_I;
	end

	// bytes moved per op
	function automatic int op_len(input bus_op_t op);
		case (op)
			READW, WRITEW: return 4;
			READH, READHU, WRITEH: return 2;
			default: return 1;
		endcase
	endfunction

	function automatic bit op_is_write(input bus_op_t op);
		return (op == WRITEB) || (op == WRITEH) || (op == WRITEW);
	endfunction

	// little endian, byte k of the word at address plus k
	task automatic model_write(input bus_op_t op, input addr_t addr, input word_t data);
		addr_t a;
		for (int k = 0; k < op_len(op); k++) begin
			a = addr + addr_t'(k);
			model_mem[a[ADDR_BITS-1:0]] = data[8*k +: 8];
		end
	endtask

	function automatic word_t model_read(input bus_op_t op, input addr_t addr);
		word_t w;
		addr_t a;
		w = '0;
		for (int k = 0; k < op_len(op); k++) begin
			a = addr + addr_t'(k);
			w[8*k +: 8] = model_mem[a[ADDR_BITS-1:0]];
		end
		// signed short loads copy the top bit of the last byte upward
		if (op == READB) begin
			w = {{24{w[7]}}, w[7:0]};
		end else if (op == READH) begin
			w = {{16{w[15]}}, w[15:0]};
		end
		return w;
	endfunction

	// prefill pattern, mixes every address bit
	function automatic word_t fill_word(input addr_t a);
		return (a * 32'h9e3779b1) ^ {a[15:0], ~a[15:0]};
	endfunction

	task automatic check_eq(input word_t got, input word_t exp, input string what);
		checks++;
		if (got !== exp) begin
			$display("[FAIL] %0t ns: %s got %08h expected %08h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic add_vec(input bus_op_t op, input addr_t addr, input word_t data,
		input bit chk, input string name);
		op_q.push_back(op);
		addr_q.push_back(addr);
		data_q.push_back(data);
		chk_q.push_back(chk);
		name_q.push_back(name);
	endtask

	// called 2 ns after a rising edge, returns at the same phase
	task automatic run_request(input bus_op_t op, input addr_t addr, input word_t data,
		input bit chk, input string name);
		int cycles;
		bit seen_done;
		word_t exp;
		cycles = 0;
		seen_done = 1'b0;
		req.op = op;
		req.addr = addr;
		req.data = data;
		en = 1'b1;
		while (!seen_done && cycles < TIMEOUT) begin
			@(posedge CLK_I);
			#1;
			cycles++;
			if (done) begin
				seen_done = 1'b1;
			end else begin
				// busy must cover every cycle up to done
				check_eq(word_t'(busy), 32'd1, {name, " busy"});
			end
		end
		if (!seen_done) begin
			$display("timeout: no done within %0d cycles for request %s", TIMEOUT, name);
			timed_out = 1'b1;
			errors++;
		end else begin
			check_eq(word_t'(busy), 32'd0, {name, " busy with done"});
			if (op_is_write(op)) begin
				model_write(op, addr, data);
			end else if (chk) begin
				exp = model_read(op, addr);
				check_eq(rdata, exp, {name, " rdata"});
			end
		end
		#1;
		en = 1'b0;
		// en stays low across the DONE to IDLE edge
		@(posedge CLK_I);
		#2;
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests++;
		$display("test %-14s %s", name, (errors == errors_before) ? "pass" : "fail");
	endtask

	initial begin
		int err0;
		int r;
		bus_op_t rop;
		addr_t raddr;
		word_t rdat;
		seed = 32'hed1d67ff;
		errors = 0;
		checks = 0;
		tests = 0;
		timed_out = 1'b0;
		RST_I = 1'b1;
		en = 1'b0;
		req = '0;

		// word write and readback
		add_vec(WRITEW, 32'h010, 32'hdeadbeef, 1'b0, "wr_word");
		add_vec(READW, 32'h010, 32'h0, 1'b1, "rd_word");
		// partial writes keep the neighbours
		add_vec(WRITEB, 32'h011, 32'h0000005a, 1'b0, "wr_byte");
		add_vec(WRITEH, 32'h012, 32'h00001234, 1'b0, "wr_half");
		add_vec(READW, 32'h010, 32'h0, 1'b1, "rd_merged");
		// sign and zero extension
		add_vec(WRITEW, 32'h020, 32'h80ff7f90, 1'b0, "wr_signed");
		add_vec(READB, 32'h020, 32'h0, 1'b1, "rd_b_sext");
		add_vec(READBU, 32'h020, 32'h0, 1'b1, "rd_bu_zext");
		add_vec(READH, 32'h020, 32'h0, 1'b1, "rd_h_sext");
		add_vec(READHU, 32'h020, 32'h0, 1'b1, "rd_hu_zext");
		add_vec(READH, 32'h022, 32'h0, 1'b1, "rd_h_hi");
		add_vec(READHU, 32'h022, 32'h0, 1'b1, "rd_hu_hi");
		add_vec(READB, 32'h021, 32'h0, 1'b1, "rd_b_pos");
		// unaligned words across a word boundary
		add_vec(WRITEW, 32'h030, 32'h11223344, 1'b0, "wr_lo");
		add_vec(WRITEW, 32'h034, 32'h55667788, 1'b0, "wr_hi");
		add_vec(READW, 32'h031, 32'h0, 1'b1, "rd_unal_1");
		add_vec(READW, 32'h033, 32'h0, 1'b1, "rd_unal_3");
		add_vec(WRITEW, 32'h032, 32'ha1b2c3d4, 1'b0, "wr_unal");
		add_vec(READW, 32'h030, 32'h0, 1'b1, "rd_lo_after");
		add_vec(READW, 32'h034, 32'h0, 1'b1, "rd_hi_after");
		add_vec(READW, 32'h032, 32'h0, 1'b1, "rd_unal_2");
		// word crossing the top of the RAM wraps to address 0
		add_vec(WRITEW, 32'h3fe, 32'hcafef00d, 1'b0, "wr_wrap");
		add_vec(READW, 32'h3fe, 32'h0, 1'b1, "rd_wrap");
		add_vec(READH, 32'h000, 32'h0, 1'b1, "rd_h_wrapped");

		repeat (4) @(posedge CLK_I);
		#2;
		RST_I = 1'b0;

		// idle outputs before the first request
		err0 = errors;
		@(posedge CLK_I);
		#1;
		check_eq(word_t'(busy), 32'd0, "busy after reset");
		check_eq(word_t'(done), 32'd0, "done after reset");
		#1;
		report_test("reset_idle", err0);

		for (int i = 0; i < op_q.size() && !timed_out; i++) begin
			err0 = errors;
			run_request(op_q[i], addr_q[i], data_q[i], chk_q[i], name_q[i]);
			report_test(name_q[i], err0);
		end

		// known contents for the random window 0x100..0x13f
		err0 = errors;
		for (int i = 0; i < 16 && !timed_out; i++) begin
			raddr = 32'h100 + addr_t'(4 * i);
			run_request(WRITEW, raddr, fill_word(raddr), 1'b0, $sformatf("fill_%0d", i));
		end
		report_test("prefill", err0);

		// random ops, words stay inside the window
		err0 = errors;
		for (int i = 0; i < 40 && !timed_out; i++) begin
			r = $random(seed);
			rop = bus_op_t'(r[2:0]);
			raddr = 32'h100 + ({$random(seed)} % 61);
			rdat = $random(seed);
			run_request(rop, raddr, rdat, 1'b1, $sformatf("rand_%0d", i));
		end
		report_test("random_ops", err0);

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0 && !timed_out) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
verilog/bus_pkg.sv
verilog/bus_op_decode.sv
verilog/bus_wb8_ctrl.sv
verilog/bus_wb8_lane.sv
verilog/bus_wb8_rdata.sv
verilog/wb8_ram.sv
verilog/bus_wb8_top.sv
dv/bus_wb8_tb.sv
